/* dv/clk_gen.sv */
// Reset is released on a falling edge so that stimulus never races the first active clock edge
module clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic g_clk,
    output logic g_resetn
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        g_clk = 1'b0;
        forever #(PERIOD_NS / 2) g_clk = ~g_clk;
    end

    initial begin
        g_resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge g_clk);   // Reset seen on these edges
        @(negedge g_clk);
        g_resetn = 1'b1;
    end

endmodule

/* dv/tb_cop_malu.sv */
// Fixed seed 94; destination pairs are reused only after both words of the pair were written back
module tb_cop_malu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_LANES  = 4;
    localparam int NUM_RANDOM = 300;
    localparam int BURST_LEN  = 8;

    logic                    g_clk;
    logic                    g_resetn;
    logic                    issue_valid;
    cop_malu_pkg::mp_op_e    issue_op;
    cop_malu_pkg::word_t     issue_rs1;
    cop_malu_pkg::word_t     issue_rs2;
    cop_malu_pkg::word_t     issue_rs3;
    cop_malu_pkg::word_t     issue_imm;
    cop_malu_pkg::cpr_addr_t issue_rd;
    logic                    issue_full;
    logic                    wb_en;
    cop_malu_pkg::cpr_addr_t wb_addr;
    cop_malu_pkg::word_t     wb_data;

    cop_malu_pkg::word_t     expected [16];   // Next word due at each register
    logic [15:0]             req_mask;        // Toggled by the issuer
    logic [15:0]             done_mask = '0;  // Toggled by the comparator
    logic [15:0]             pending;
    int                      seed;
    int                      issued;
    int                      cycles;
    logic                    full_seen;
    int                      shift_cases [4] = '{0, 31, 32, 63};

    assign pending = req_mask ^ done_mask;

    clk_gen #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (4)
    ) clk_gen_inst (
        .g_clk    (g_clk),
        .g_resetn (g_resetn)
    );

    cop_malu_cluster #(
        .NUM_LANES (NUM_LANES)
    ) cop_malu_cluster_inst (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_rs3   (issue_rs3),
        .issue_imm   (issue_imm),
        .issue_rd    (issue_rd),
        .issue_full  (issue_full),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data)
    );

    // Expected 64-bit pair, low word for rd and high word for rd plus one
    function automatic cop_malu_pkg::dword_t ref_result(
        input cop_malu_pkg::mp_op_e op,
        input cop_malu_pkg::word_t  rs1,
        input cop_malu_pkg::word_t  rs2,
        input cop_malu_pkg::word_t  rs3,
        input cop_malu_pkg::word_t  imm
    );
        cop_malu_pkg::dword_t a;
        cop_malu_pkg::dword_t b;
        cop_malu_pkg::dword_t c;
        cop_malu_pkg::dword_t pair;
        a    = {32'h0, rs1};
        b    = {32'h0, rs2};
        c    = {32'h0, rs3};
        pair = {rs1, rs2};
        case (op)
            cop_malu_pkg::ADD2: return a + b;
            cop_malu_pkg::ADD3: return a + b + c;
            cop_malu_pkg::SUB2: return a - b;       // Borrow wraps into an all-ones high word
            cop_malu_pkg::SUB3: return a - b - c;
            cop_malu_pkg::SLL:  return pair << rs3[5:0];
            cop_malu_pkg::SLLI: return pair << imm[5:0];
            cop_malu_pkg::SRL:  return pair >> rs3[5:0];
            cop_malu_pkg::SRLI: return pair >> imm[5:0];
            default:            return '0;
        endcase
    endfunction

    function automatic cop_malu_pkg::word_t rand_word();
        return $random(seed);
    endfunction

    function automatic cop_malu_pkg::mp_op_e op_from_index(input int idx);
        case (idx & 7)
            0:       return cop_malu_pkg::ADD2;
            1:       return cop_malu_pkg::ADD3;
            2:       return cop_malu_pkg::SUB2;
            3:       return cop_malu_pkg::SUB3;
            4:       return cop_malu_pkg::SLLI;
            5:       return cop_malu_pkg::SLL;
            6:       return cop_malu_pkg::SRLI;
            default: return cop_malu_pkg::SRL;
        endcase
    endfunction

    task automatic fail_with(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Random start point so that all eight pairs get used
    task automatic get_free_pair(output cop_malu_pkg::cpr_addr_t rd);
        int  start;
        int  idx;
        logic found;
        found = 1'b0;
        rd    = '0;
        while (!found) begin
            start = $random(seed) & 7;
            for (int k = 0; k < 8; k++) begin
                idx = (start + k) % 8;
                if (!found && pending[2 * idx +: 2] == 2'b00) begin
                    rd    = cop_malu_pkg::cpr_addr_t'(2 * idx);
                    found = 1'b1;
                end
            end
            if (!found) begin
                @(negedge g_clk);                    // Every pair still in flight
            end
        end
    endtask

    // Called on a falling edge and returns on the next one
    task automatic issue_instr(
        input cop_malu_pkg::mp_op_e op,
        input cop_malu_pkg::word_t  rs1,
        input cop_malu_pkg::word_t  rs2,
        input cop_malu_pkg::word_t  rs3,
        input cop_malu_pkg::word_t  imm
    );
        cop_malu_pkg::cpr_addr_t rd;
        cop_malu_pkg::dword_t    value;
        get_free_pair(rd);
        while (issue_full) begin
            full_seen = 1'b1;
            @(negedge g_clk);
        end
        value                   = ref_result(op, rs1, rs2, rs3, imm);
        expected[rd]            = value[31:0];
        expected[rd | 4'd1]     = value[63:32];
        req_mask[rd]            = ~req_mask[rd];
        req_mask[rd | 4'd1]     = ~req_mask[rd | 4'd1];
        issue_valid = 1'b1;
        issue_op    = op;
        issue_rs1   = rs1;
        issue_rs2   = rs2;
        issue_rs3   = rs3;
        issue_imm   = imm;
        issue_rd    = rd;
        issued++;
        @(negedge g_clk);
        issue_valid = 1'b0;
    endtask

    task automatic drain();
        while (pending != 16'h0) begin
            @(negedge g_clk);
        end
    endtask

    task automatic run_shift_set(input int amt);
        cop_malu_pkg::word_t amt_word;
        amt_word = (rand_word() & 32'hFFFF_FFC0) | cop_malu_pkg::word_t'(amt); // Upper bits ignored
        issue_instr(cop_malu_pkg::SLL, rand_word(), rand_word(), amt_word, rand_word());
        issue_instr(cop_malu_pkg::SLLI, rand_word(), rand_word(), rand_word(), amt_word);
        issue_instr(cop_malu_pkg::SRL, rand_word(), rand_word(), amt_word, rand_word());
        issue_instr(cop_malu_pkg::SRLI, rand_word(), rand_word(), rand_word(), amt_word);
    endtask

    // Write-back checker, one word per wb_en cycle
    always @(posedge g_clk) begin
        if (g_resetn && wb_en) begin
            assert (pending[wb_addr] && wb_data == expected[wb_addr]) begin
                done_mask[wb_addr] <= ~done_mask[wb_addr];
            end else begin
                fail_with($sformatf("ERROR: %0d ns: r%0d written with %h, expected %h, pending %b",
                                    $time, wb_addr, wb_data, expected[wb_addr], pending[wb_addr]));
            end
        end
    end

    // Bound grows with every issued instruction
    initial begin
        cycles = 0;
        while (cycles <= 20 * issued + 200) begin
            @(posedge g_clk);
            cycles++;
        end
        fail_with($sformatf("Timeout: run exceeded %0d cycles with %0d instructions issued",
                            cycles, issued));
    end

    initial begin
        seed        = 94;
        issued      = 0;
        full_seen   = 1'b0;
        req_mask    = '0;
        issue_valid = 1'b0;
        issue_op    = cop_malu_pkg::ADD2;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_rs3   = '0;
        issue_imm   = '0;
        issue_rd    = '0;
        for (int r = 0; r < 16; r++) begin
            expected[r] = '0;
        end
        wait (g_resetn === 1'b1);

        // Quiet after reset
        repeat (10) begin
            @(negedge g_clk);
            assert (!issue_full && !wb_en) else begin
                fail_with($sformatf("ERROR: %0d ns: idle cluster shows issue_full %b wb_en %b",
                                    $time, issue_full, wb_en));
            end
        end

        // Carries into the high word
        issue_instr(cop_malu_pkg::ADD2, 32'hFFFF_FFFF, 32'hFFFF_FFFF, '0, '0);
        issue_instr(cop_malu_pkg::ADD3, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, '0);
        issue_instr(cop_malu_pkg::ADD2, 32'hFFFF_FFFF, 32'h0000_0001, '0, '0);
        for (int i = 0; i < 6; i++) begin
            issue_instr(cop_malu_pkg::ADD2, rand_word(), rand_word(), rand_word(), rand_word());
            issue_instr(cop_malu_pkg::ADD3, rand_word(), rand_word(), rand_word(), rand_word());
        end
        drain();

        // Borrow and no-borrow cases
        issue_instr(cop_malu_pkg::SUB2, 32'd5, 32'd3, '0, '0);
        issue_instr(cop_malu_pkg::SUB2, 32'd3, 32'd5, '0, '0);
        issue_instr(cop_malu_pkg::SUB2, 32'h8000_0000, 32'h8000_0000, '0, '0);
        issue_instr(cop_malu_pkg::SUB3, 32'd10, 32'd3, 32'd4, '0);
        issue_instr(cop_malu_pkg::SUB3, 32'd10, 32'd3, 32'd8, '0);
        issue_instr(cop_malu_pkg::SUB3, 32'h0, 32'h0, 32'h1, '0);
        for (int i = 0; i < 6; i++) begin
            issue_instr(cop_malu_pkg::SUB2, rand_word(), rand_word(), rand_word(), rand_word());
            issue_instr(cop_malu_pkg::SUB3, rand_word(), rand_word(), rand_word(), rand_word());
        end
        drain();

        // Edge shift amounts, then random ones
        for (int k = 0; k < 4; k++) begin
            run_shift_set(shift_cases[k]);
        end
        for (int i = 0; i < 6; i++) begin
            run_shift_set($random(seed) & 63);
        end
        drain();

        // Back-to-back burst into idle lanes
        full_seen = 1'b0;
        for (int i = 0; i < BURST_LEN; i++) begin
            issue_instr(op_from_index(i), rand_word(), rand_word(), rand_word(), rand_word());
        end
        drain();
        assert (full_seen) else begin
            fail_with("issue_full never rose during the back-to-back burst");
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            issue_instr(op_from_index($random(seed)), rand_word(), rand_word(), rand_word(),
                        rand_word());
        end
        drain();
        repeat (10) @(negedge g_clk);                 // Stray writes would fail here

        assert (pending == 16'h0) begin
            $display("** PASS **");
            $finish;
        end else begin
            fail_with($sformatf("Results still pending at the end, mask %h", pending));
        end
    end

endmodule

/* rtl/cop_malu_cluster.sv */
// NUM_LANES from 1 to 8; no hazard check, so a pending destination pair must not be reissued
module cop_malu_cluster #(
    parameter int NUM_LANES = 4
) (
    input  logic                    g_clk,
    input  logic                    g_resetn,

    input  logic                    issue_valid,   // Ignored while issue_full
    input  cop_malu_pkg::mp_op_e    issue_op,
    input  cop_malu_pkg::word_t     issue_rs1,
    input  cop_malu_pkg::word_t     issue_rs2,
    input  cop_malu_pkg::word_t     issue_rs3,
    input  cop_malu_pkg::word_t     issue_imm,
    input  cop_malu_pkg::cpr_addr_t issue_rd,      // Even
    output logic                    issue_full,

    output logic                    wb_en,
    output cop_malu_pkg::cpr_addr_t wb_addr,
    output cop_malu_pkg::word_t     wb_data
);

    lane_issue_if  issue_if  [NUM_LANES] ();
    lane_result_if result_if [NUM_LANES] ();

    malu_dispatch #(
        .NUM_LANES (NUM_LANES)
    ) dispatch_inst (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_rs3   (issue_rs3),
        .issue_imm   (issue_imm),
        .issue_rd    (issue_rd),
        .issue_full  (issue_full),
        .lanes       (issue_if)
    );

    // Identical lanes, one instruction each
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lanes
        malu_lane lane_inst (
            .g_clk    (g_clk),
            .g_resetn (g_resetn),
            .issue    (issue_if[i]),
            .result   (result_if[i])
        );
    end

    malu_writeback #(
        .NUM_LANES (NUM_LANES)
    ) writeback_inst (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .lanes    (result_if),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

endmodule

/* rtl/cop_malu_pkg.sv */
// Only the MP subclasses kept by the cluster are encoded; compare, accumulate and MAC codes are absent
package cop_malu_pkg;

    // Data widths
    typedef logic [31:0] word_t;       // One coprocessor register
    typedef logic [63:0] dword_t;      // High word lands in rd plus one
    typedef logic [3:0]  cpr_addr_t;   // 16 registers
    typedef logic [5:0]  shamt_t;      // Shift of the 64-bit pair

    // Coprocessor MP subclass field
    typedef enum logic [3:0] {
        ADD3 = 4'b0100,   // rs1 + rs2 + rs3
        ADD2 = 4'b0101,   // rs1 + rs2
        SUB3 = 4'b0110,   // rs1 - rs2 - rs3
        SUB2 = 4'b0111,   // rs1 - rs2
        SLLI = 4'b1000,
        SLL  = 4'b1001,
        SRLI = 4'b1010,
        SRL  = 4'b1011
    } mp_op_e;

    // Lane FSM
    typedef enum logic [1:0] {
        IDLE,    // Free for a new start
        STEP1,   // First adder pass or the shift
        STEP2,   // Second pass against rs3
        HOLD     // Result waits for ack
    } lane_state_e;

endpackage

/* rtl/lane_issue_if.sv */
// Fields are only valid from a start pulse until the lane's busy falls again
interface lane_issue_if;

    logic                    start;   // One-cycle pulse
    cop_malu_pkg::mp_op_e    op;
    cop_malu_pkg::word_t     rs1;
    cop_malu_pkg::word_t     rs2;
    cop_malu_pkg::word_t     rs3;
    cop_malu_pkg::word_t     imm;
    cop_malu_pkg::cpr_addr_t rd;      // Even register of the pair
    logic                    busy;    // High from the cycle after start until ack

    modport dispatch (
        output start, op, rs1, rs2, rs3, imm, rd,
        input  busy
    );

    modport lane (
        input  start, op, rs1, rs2, rs3, imm, rd,
        output busy
    );

endinterface

/* rtl/lane_result_if.sv */
// Result and rd hold steady while valid is high, until the ack pulse
interface lane_result_if;

    logic                    valid;    // Level, drops the cycle after ack
    cop_malu_pkg::cpr_addr_t rd;
    cop_malu_pkg::dword_t    result;
    logic                    ack;      // Given with the high word write

    modport lane (
        output valid, rd, result,
        input  ack
    );

    modport collect (
        input  valid, rd, result,
        output ack
    );

endinterface

/* rtl/malu_dispatch.sv */
// issue_full is registered and conservative; an issue while it is high is dropped
module malu_dispatch #(
    parameter int NUM_LANES = 4
) (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    issue_valid,
    input  cop_malu_pkg::mp_op_e    issue_op,
    input  cop_malu_pkg::word_t     issue_rs1,
    input  cop_malu_pkg::word_t     issue_rs2,
    input  cop_malu_pkg::word_t     issue_rs3,
    input  cop_malu_pkg::word_t     issue_imm,
    input  cop_malu_pkg::cpr_addr_t issue_rd,
    output logic                    issue_full,
    lane_issue_if.dispatch          lanes [NUM_LANES]
);

    logic [NUM_LANES-1:0] busy;
    logic [NUM_LANES-1:0] start_q;   // Doubles as the pending mark
    logic [NUM_LANES-1:0] free;
    logic [NUM_LANES-1:0] pick;
    logic [NUM_LANES-1:0] sel;
    logic                 accept;

    assign free   = ~(busy | start_q);
    assign pick   = free & (~free + 1'b1);   // Lowest-index free lane
    assign accept = issue_valid && !issue_full;
    assign sel    = accept ? pick : '0;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            start_q    <= '0;
            issue_full <= 1'b0;
        end else begin
            start_q    <= sel;
            // Lanes surely occupied next cycle
            issue_full <= &(busy | start_q | sel);
        end
    end

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        assign busy[i]        = lanes[i].busy;
        assign lanes[i].start = start_q[i];

        // Fields stay put until this lane is chosen again
        always_ff @(posedge g_clk) begin
            if (sel[i]) begin
                lanes[i].op  <= issue_op;
                lanes[i].rs1 <= issue_rs1;
                lanes[i].rs2 <= issue_rs2;
                lanes[i].rs3 <= issue_rs3;
                lanes[i].imm <= issue_imm;
                lanes[i].rd  <= issue_rd;
            end
        end
    end

endmodule

/* rtl/malu_lane.sv */
// Reads operands straight from the issue fields, which must not change until ack
module malu_lane (
    input  logic        g_clk,
    input  logic        g_resetn,
    lane_issue_if.lane  issue,
    lane_result_if.lane result
);

    cop_malu_pkg::lane_state_e state;
    cop_malu_pkg::lane_state_e state_next;
    cop_malu_pkg::dword_t      inter;       // Intermediate and final value

    logic                      is_sub;
    logic                      is_three;
    logic                      is_shift;
    logic                      shift_right;
    logic                      shamt_reg;
    cop_malu_pkg::shamt_t      shamt;

    cop_malu_pkg::dword_t      add_lhs;
    cop_malu_pkg::dword_t      add_rhs;
    logic [64:0]               add_sum;
    cop_malu_pkg::dword_t      shift_src;
    cop_malu_pkg::dword_t      shift_res;

    // Subclass decode
    assign is_sub      = issue.op inside {cop_malu_pkg::SUB2, cop_malu_pkg::SUB3};
    assign is_three    = issue.op inside {cop_malu_pkg::ADD3, cop_malu_pkg::SUB3};
    assign is_shift    = issue.op inside {cop_malu_pkg::SLLI, cop_malu_pkg::SLL,
                                          cop_malu_pkg::SRLI, cop_malu_pkg::SRL};
    assign shift_right = issue.op inside {cop_malu_pkg::SRLI, cop_malu_pkg::SRL};
    assign shamt_reg   = issue.op inside {cop_malu_pkg::SLL, cop_malu_pkg::SRL};

    // Second pass works on the stored first-pass sum
    assign add_lhs = (state == cop_malu_pkg::STEP2) ? inter : {32'b0, issue.rs1};
    assign add_rhs = (state == cop_malu_pkg::STEP2) ? {32'b0, issue.rs3} : {32'b0, issue.rs2};

    // Bit 0 of each operand carries the subtract carry-in into bit 1
    assign add_sum = {add_lhs, 1'b1} + {add_rhs ^ {64{is_sub}}, is_sub};

    // Amount from rs3 for sll and srl, imm otherwise
    assign shamt     = shamt_reg ? issue.rs3[5:0] : issue.imm[5:0];
    assign shift_src = {issue.rs1, issue.rs2};
    assign shift_res = shift_right ? (shift_src >> shamt) : (shift_src << shamt);

    always_comb begin
        state_next = state;
        case (state)
            cop_malu_pkg::IDLE: begin
                if (issue.start) begin
                    state_next = cop_malu_pkg::STEP1;
                end
            end
            cop_malu_pkg::STEP1: begin
                state_next = is_three ? cop_malu_pkg::STEP2 : cop_malu_pkg::HOLD;
            end
            cop_malu_pkg::STEP2: begin
                state_next = cop_malu_pkg::HOLD;
            end
            cop_malu_pkg::HOLD: begin
                if (result.ack) begin
                    state_next = cop_malu_pkg::IDLE;
                end
            end
            default: state_next = cop_malu_pkg::IDLE;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state <= cop_malu_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge g_clk) begin
        if (state == cop_malu_pkg::STEP1) begin
            inter <= is_shift ? shift_res : add_sum[64:1];
        end else if (state == cop_malu_pkg::STEP2) begin
            inter <= add_sum[64:1];                  // Adds or subtracts rs3
        end
    end

    assign issue.busy    = (state != cop_malu_pkg::IDLE);
    assign result.valid  = (state == cop_malu_pkg::HOLD);
    assign result.rd     = issue.rd;
    assign result.result = inter;

    // The dispatcher never starts an occupied lane
    a_no_start_busy: assert property (@(posedge g_clk) disable iff (!g_resetn)
        issue.start |-> !issue.busy);

    // Ack only arrives while the result is held
    a_ack_in_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        result.ack |-> (state == cop_malu_pkg::HOLD));

    a_result_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        result.valid && !result.ack |=>
            result.valid && $stable(result.result) && $stable(result.rd));

endmodule

/* rtl/malu_writeback.sv */
// Lane 0 always wins; one result pair is drained every three cycles at best
module malu_writeback #(
    parameter int NUM_LANES = 4
) (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    lane_result_if.collect          lanes [NUM_LANES],
    output logic                    wb_en,
    output cop_malu_pkg::cpr_addr_t wb_addr,
    output cop_malu_pkg::word_t     wb_data
);

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_LO,     // Low word to rd
        WB_HI      // High word to rd plus one, with ack
    } wb_state_e;

    wb_state_e               state;
    logic [NUM_LANES-1:0]    valid_v;
    logic [NUM_LANES-1:0]    pick;
    logic [NUM_LANES-1:0]    sel_q;     // Lane being drained
    cop_malu_pkg::cpr_addr_t rd_v [NUM_LANES];
    cop_malu_pkg::dword_t    res_v [NUM_LANES];
    cop_malu_pkg::cpr_addr_t pick_rd;
    cop_malu_pkg::dword_t    pick_res;
    cop_malu_pkg::cpr_addr_t rd_q;
    cop_malu_pkg::dword_t    data_q;
    logic                    take;

    assign pick = valid_v & (~valid_v + 1'b1);
    assign take = (state == WB_IDLE) && (|valid_v);

    always_comb begin
        pick_rd  = '0;
        pick_res = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (pick[i]) begin
                pick_rd  = rd_v[i];
                pick_res = res_v[i];
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state <= WB_IDLE;
        end else begin
            case (state)
                WB_IDLE: state <= take ? WB_LO : WB_IDLE;
                WB_LO:   state <= WB_HI;
                default: state <= WB_IDLE;
            endcase
        end
    end

    always_ff @(posedge g_clk) begin
        if (take) begin
            sel_q  <= pick;
            rd_q   <= pick_rd;
            data_q <= pick_res;
        end
    end

    assign wb_en   = (state == WB_LO) || (state == WB_HI);
    assign wb_addr = (state == WB_HI) ? {rd_q[3:1], 1'b1} : rd_q;
    assign wb_data = (state == WB_HI) ? data_q[63:32] : data_q[31:0];

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        assign valid_v[i]   = lanes[i].valid;
        assign rd_v[i]      = lanes[i].rd;
        assign res_v[i]     = lanes[i].result;
        assign lanes[i].ack = (state == WB_HI) && sel_q[i];
    end

    // Pair base must be even so the high word goes to the odd neighbour
    a_rd_even: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (state == WB_LO) |-> !rd_q[0]);

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module tb_cop_malu -f verilog.f -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log

grep -qF '** PASS **' sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* verilog.f */
rtl/cop_malu_pkg.sv
rtl/lane_issue_if.sv
rtl/lane_result_if.sv
rtl/malu_dispatch.sv
rtl/malu_lane.sv
rtl/malu_writeback.sv
rtl/cop_malu_cluster.sv
dv/clk_gen.sv
dv/tb_cop_malu.sv
